//--- src/mips_isa_pkg.sv
package mips_isa_pkg;

	typedef logic [31:0] word_t;	// data / address word
	typedef logic [4:0] reg_addr_t;	// register number

	localparam word_t reset_pc = 32'h0000_4000;	// first fetch
	localparam int mem_words = 1024;	// unified memory depth
	localparam int mem_aw = $clog2(mem_words);	// word index bits
	localparam reg_addr_t link_reg = 5'd31;	// jal return register

	// primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addiu = 6'h09,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// r-type function field, bits 5:0
	typedef enum logic [5:0] {
		f_sll  = 6'h00,
		f_srl  = 6'h02,
		f_addu = 6'h21,
		f_subu = 6'h23,
		f_and  = 6'h24,
		f_or   = 6'h25,
		f_xor  = 6'h26,
		f_nor  = 6'h27,
		f_slt  = 6'h2a
	} funct_e;

	// r-type layout; imm is [15:0], jump target is [25:0]
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

endpackage

//--- src/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sll,
		alu_srl
	} alu_op_e;

	typedef enum logic [1:0] {
		src_a_reg,	// A register
		src_a_pc,
		src_a_shamt	// shift amount from ir
	} src_a_e;

	typedef enum logic [1:0] {
		src_b_reg,	// B register
		src_b_ext,	// extended imm
		src_b_four,
		src_b_ext_sh2	// branch offset
	} src_b_e;

	typedef enum logic [1:0] {dst_rt, dst_rd, dst_link} reg_dst_e;

	typedef enum logic [1:0] {pc_src_alu, pc_src_alu_out, pc_src_jump} pc_src_e;

	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_mem_addr,
		st_mem_rd,
		st_mem_wb,
		st_mem_wr,
		st_r_exec,
		st_i_exec,
		st_alu_wb,
		st_branch,
		st_jump,
		st_halt
	} ctrl_state_e;

	typedef struct packed {
		logic pc_write;	// unconditional pc load
		logic branch_eq;
		logic branch_ne;
		logic i_or_d;	// 1 = data address from alu_out
		logic mem_write;
		logic ir_write;
		logic reg_write;
		logic mem_to_reg;
		logic zero_ext;	// logical immediates
		src_a_e alu_src_a;
		src_b_e alu_src_b;
		reg_dst_e reg_dst;
		pc_src_e pc_src;
		alu_op_e alu_op;
	} ctrl_word_t;

	// nothing written, alu adds A and B
	localparam ctrl_word_t ctrl_idle = '{
		pc_write: 1'b0, branch_eq: 1'b0, branch_ne: 1'b0, i_or_d: 1'b0,
		mem_write: 1'b0, ir_write: 1'b0, reg_write: 1'b0, mem_to_reg: 1'b0,
		zero_ext: 1'b0, alu_src_a: src_a_reg, alu_src_b: src_b_reg,
		reg_dst: dst_rt, pc_src: pc_src_alu, alu_op: alu_add
	};

endpackage

//--- src/mips_alu.sv
`timescale 1ns/10ps

module mips_alu (
	input mips_isa_pkg::word_t a,
	input mips_isa_pkg::word_t b,
	input mips_ctrl_pkg::alu_op_e op,
	output mips_isa_pkg::word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			mips_ctrl_pkg::alu_add: result = a + b;
			mips_ctrl_pkg::alu_sub: result = a - b;	// also the beq/bne compare
			mips_ctrl_pkg::alu_and: result = a & b;
			mips_ctrl_pkg::alu_or:  result = a | b;
			mips_ctrl_pkg::alu_xor: result = a ^ b;
			mips_ctrl_pkg::alu_nor: result = ~(a | b);
			mips_ctrl_pkg::alu_slt: begin
				// signed compare, result is 0 or 1
				result = {31'b0, $signed(a) < $signed(b)};
			end
			mips_ctrl_pkg::alu_sll: result = b << a[4:0];	// shamt comes in on a
			mips_ctrl_pkg::alu_srl: result = b >> a[4:0];	// logical, zero fill
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);	// branch condition

endmodule

//--- src/mips_regfile.sv
`timescale 1ns/10ps

module mips_regfile (
	input logic clk,
	input logic rstb,
	input mips_isa_pkg::reg_addr_t rd_addr1,
	input mips_isa_pkg::reg_addr_t rd_addr2,
	input mips_isa_pkg::reg_addr_t wr_addr,
	input mips_isa_pkg::word_t wr_data,
	input logic wr_ena,
	output mips_isa_pkg::word_t rd_data1,
	output mips_isa_pkg::word_t rd_data2
);

	mips_isa_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wr_ena && wr_addr != '0) begin	// $zero stays 0
			regs[wr_addr] <= wr_data;
		end
	end

	// async read ports
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

//--- src/mips_control.sv
`timescale 1ns/10ps

module mips_control (
	input logic clk,
	input logic rstb,
	input mips_isa_pkg::instr_t instr,
	output mips_ctrl_pkg::ctrl_state_e state,
	output mips_ctrl_pkg::ctrl_word_t ctrl
);

	mips_ctrl_pkg::ctrl_state_e next_state;
	mips_ctrl_pkg::alu_op_e r_op;	// alu op for r-type funct
	logic r_known;	// funct is supported
	logic is_shift;

	// alu decoder
	always_comb begin
		r_known = 1'b1;
		is_shift = 1'b0;
		case (instr.funct)
			mips_isa_pkg::f_addu: r_op = mips_ctrl_pkg::alu_add;
			mips_isa_pkg::f_subu: r_op = mips_ctrl_pkg::alu_sub;
			mips_isa_pkg::f_and:  r_op = mips_ctrl_pkg::alu_and;
			mips_isa_pkg::f_or:   r_op = mips_ctrl_pkg::alu_or;
			mips_isa_pkg::f_xor:  r_op = mips_ctrl_pkg::alu_xor;
			mips_isa_pkg::f_nor:  r_op = mips_ctrl_pkg::alu_nor;
			mips_isa_pkg::f_slt:  r_op = mips_ctrl_pkg::alu_slt;
			mips_isa_pkg::f_sll: begin
				r_op = mips_ctrl_pkg::alu_sll;
				is_shift = 1'b1;
			end
			mips_isa_pkg::f_srl: begin
				r_op = mips_ctrl_pkg::alu_srl;
				is_shift = 1'b1;
			end
			default: begin
				r_op = mips_ctrl_pkg::alu_add;
				r_known = 1'b0;	// goes to halt
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstb) state <= mips_ctrl_pkg::st_fetch;
		else state <= next_state;
	end

	// next state, opcode only looked at in decode and mem_addr
	always_comb begin
		next_state = mips_ctrl_pkg::st_fetch;	// most states end here
		case (state)
			mips_ctrl_pkg::st_fetch: next_state = mips_ctrl_pkg::st_decode;
			mips_ctrl_pkg::st_decode: begin
				case (instr.opcode)
					mips_isa_pkg::op_rtype:
						next_state = r_known ? mips_ctrl_pkg::st_r_exec : mips_ctrl_pkg::st_halt;
					mips_isa_pkg::op_lw, mips_isa_pkg::op_sw:
						next_state = mips_ctrl_pkg::st_mem_addr;
					mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti,
					mips_isa_pkg::op_andi, mips_isa_pkg::op_ori:
						next_state = mips_ctrl_pkg::st_i_exec;
					mips_isa_pkg::op_beq, mips_isa_pkg::op_bne:
						next_state = mips_ctrl_pkg::st_branch;
					mips_isa_pkg::op_j, mips_isa_pkg::op_jal:
						next_state = mips_ctrl_pkg::st_jump;
					default: next_state = mips_ctrl_pkg::st_halt;	// unknown opcode
				endcase
			end
			mips_ctrl_pkg::st_mem_addr:
				next_state = (instr.opcode == mips_isa_pkg::op_lw) ?
					mips_ctrl_pkg::st_mem_rd : mips_ctrl_pkg::st_mem_wr;
			mips_ctrl_pkg::st_mem_rd: next_state = mips_ctrl_pkg::st_mem_wb;
			mips_ctrl_pkg::st_r_exec, mips_ctrl_pkg::st_i_exec:
				next_state = mips_ctrl_pkg::st_alu_wb;
			mips_ctrl_pkg::st_halt: next_state = mips_ctrl_pkg::st_halt;	// stuck until reset
			default: next_state = mips_ctrl_pkg::st_fetch;
		endcase
	end

	// control word per state
	always_comb begin
		ctrl = mips_ctrl_pkg::ctrl_idle;
		case (state)
			mips_ctrl_pkg::st_fetch: begin	// ir <= mem[pc], pc <= pc + 4
				ctrl.pc_write = 1'b1;
				ctrl.ir_write = 1'b1;
				ctrl.alu_src_a = mips_ctrl_pkg::src_a_pc;
				ctrl.alu_src_b = mips_ctrl_pkg::src_b_four;
			end
			mips_ctrl_pkg::st_decode: begin	// branch target into alu_out
				ctrl.alu_src_a = mips_ctrl_pkg::src_a_pc;
				ctrl.alu_src_b = mips_ctrl_pkg::src_b_ext_sh2;
			end
			mips_ctrl_pkg::st_mem_addr: ctrl.alu_src_b = mips_ctrl_pkg::src_b_ext;
			mips_ctrl_pkg::st_mem_rd: ctrl.i_or_d = 1'b1;
			mips_ctrl_pkg::st_mem_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;	// rt <= mdr
			end
			mips_ctrl_pkg::st_mem_wr: begin
				ctrl.i_or_d = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			mips_ctrl_pkg::st_r_exec: begin
				ctrl.alu_src_a = is_shift ? mips_ctrl_pkg::src_a_shamt : mips_ctrl_pkg::src_a_reg;
				ctrl.alu_op = r_op;
			end
			mips_ctrl_pkg::st_i_exec: begin
				ctrl.alu_src_b = mips_ctrl_pkg::src_b_ext;
				case (instr.opcode)
					mips_isa_pkg::op_slti: ctrl.alu_op = mips_ctrl_pkg::alu_slt;
					mips_isa_pkg::op_andi: begin
						ctrl.alu_op = mips_ctrl_pkg::alu_and;
						ctrl.zero_ext = 1'b1;
					end
					mips_isa_pkg::op_ori: begin
						ctrl.alu_op = mips_ctrl_pkg::alu_or;
						ctrl.zero_ext = 1'b1;
					end
					default: ctrl.alu_op = mips_ctrl_pkg::alu_add;	// addiu
				endcase
			end
			mips_ctrl_pkg::st_alu_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst = (instr.opcode == mips_isa_pkg::op_rtype) ?
					mips_ctrl_pkg::dst_rd : mips_ctrl_pkg::dst_rt;
			end
			mips_ctrl_pkg::st_branch: begin	// compare A and B, target from alu_out
				ctrl.alu_op = mips_ctrl_pkg::alu_sub;
				ctrl.pc_src = mips_ctrl_pkg::pc_src_alu_out;
				ctrl.branch_eq = (instr.opcode == mips_isa_pkg::op_beq);
				ctrl.branch_ne = (instr.opcode == mips_isa_pkg::op_bne);
			end
			mips_ctrl_pkg::st_jump: begin
				ctrl.pc_write = 1'b1;
				ctrl.pc_src = mips_ctrl_pkg::pc_src_jump;
				if (instr.opcode == mips_isa_pkg::op_jal) begin
					ctrl.reg_write = 1'b1;	// $ra <= pc
					ctrl.reg_dst = mips_ctrl_pkg::dst_link;
				end
			end
			default: ctrl = mips_ctrl_pkg::ctrl_idle;	// halt
		endcase
	end

endmodule

//--- src/mips_core.sv
`timescale 1ns/10ps

module mips_core (
	input logic clk,
	input logic rstb,
	input mips_isa_pkg::word_t mem_rd_data,
	output mips_isa_pkg::word_t mem_addr,
	output mips_isa_pkg::word_t mem_wr_data,
	output logic mem_wr_ena,
	output mips_isa_pkg::word_t pc
);

	mips_isa_pkg::instr_t ir;
	mips_isa_pkg::word_t a_reg, b_reg, alu_out, mdr;	// multicycle holding regs
	mips_isa_pkg::word_t rd_data1, rd_data2;
	mips_isa_pkg::word_t src_a, src_b, alu_result;
	mips_isa_pkg::word_t ext_imm, jump_target, wr_data;
	mips_isa_pkg::reg_addr_t wr_addr;
	mips_ctrl_pkg::ctrl_word_t ctrl;
	mips_ctrl_pkg::ctrl_state_e state;
	logic zero;
	logic pc_en;

	mips_control u_control (
		.clk(clk),
		.rstb(rstb),
		.instr(ir),
		.state(state),
		.ctrl(ctrl)
	);

	// sign or zero extended imm
	assign ext_imm = ctrl.zero_ext ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
	assign jump_target = {pc[31:28], ir[25:0], 2'b00};	// pc already +4

	// alu operand muxes
	always_comb begin
		case (ctrl.alu_src_a)
			mips_ctrl_pkg::src_a_pc: src_a = pc;
			mips_ctrl_pkg::src_a_shamt: src_a = {27'b0, ir.shamt};
			default: src_a = a_reg;
		endcase
		case (ctrl.alu_src_b)
			mips_ctrl_pkg::src_b_ext: src_b = ext_imm;
			mips_ctrl_pkg::src_b_four: src_b = 32'd4;
			mips_ctrl_pkg::src_b_ext_sh2: src_b = {ext_imm[29:0], 2'b00};
			default: src_b = b_reg;
		endcase
	end

	mips_alu u_alu (
		.a(src_a),
		.b(src_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.zero(zero)
	);

	// writeback select
	always_comb begin
		case (ctrl.reg_dst)
			mips_ctrl_pkg::dst_rd: wr_addr = ir.rd;
			mips_ctrl_pkg::dst_link: wr_addr = mips_isa_pkg::link_reg;
			default: wr_addr = ir.rt;
		endcase
		if (ctrl.reg_dst == mips_ctrl_pkg::dst_link) wr_data = pc;	// jal return addr
		else if (ctrl.mem_to_reg) wr_data = mdr;
		else wr_data = alu_out;
	end

	mips_regfile u_regfile (
		.clk(clk),
		.rstb(rstb),
		.rd_addr1(ir.rs),
		.rd_addr2(ir.rt),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_ena(ctrl.reg_write),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2)
	);

	assign pc_en = ctrl.pc_write | (ctrl.branch_eq & zero) | (ctrl.branch_ne & ~zero);

	// pc and ir
	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc <= mips_isa_pkg::reset_pc;
			ir <= '0;
		end else begin
			if (ctrl.ir_write) ir <= mem_rd_data;
			if (pc_en) begin
				case (ctrl.pc_src)
					mips_ctrl_pkg::pc_src_alu_out: pc <= alu_out;	// branch target
					mips_ctrl_pkg::pc_src_jump: pc <= jump_target;
					default: pc <= alu_result;	// pc + 4
				endcase
			end
		end
	end

	// datapath regs, no reset
	always_ff @(posedge clk) begin
		a_reg <= rd_data1;
		b_reg <= rd_data2;
		alu_out <= alu_result;
		if (state == mips_ctrl_pkg::st_mem_rd) mdr <= mem_rd_data;	// lw data
	end

	assign mem_addr = ctrl.i_or_d ? alu_out : pc;
	assign mem_wr_data = b_reg;	// sw stores rt
	assign mem_wr_ena = ctrl.mem_write;

endmodule

//--- src/mips_memory.sv
`timescale 1ns/10ps

module mips_memory (
	input logic clk,
	input mips_isa_pkg::word_t addr,
	input mips_isa_pkg::word_t wr_data,
	input logic wr_ena,
	output mips_isa_pkg::word_t rd_data
);

	mips_isa_pkg::word_t mem [mips_isa_pkg::mem_words];
	logic [mips_isa_pkg::mem_aw-1:0] word_idx;	// addr modulo memory size

	// program image, reset_pc lands on word 0
	initial begin
		$readmemh("program.hex", mem);
	end

	assign word_idx = addr[mips_isa_pkg::mem_aw+1:2];	// drop byte offset
	assign rd_data = mem[word_idx];	// combinational read

	always_ff @(posedge clk) begin
		if (wr_ena) mem[word_idx] <= wr_data;
	end

endmodule

//--- src/mips_system.sv
`timescale 1ns/10ps

module mips_system (
	input logic clk,
	input logic rstb,
	output mips_isa_pkg::word_t pc,
	output mips_isa_pkg::word_t mem_addr,
	output mips_isa_pkg::word_t mem_wr_data,
	output logic mem_wr_ena
);

	mips_isa_pkg::word_t mem_rd_data;	// memory to core

	mips_core u_core (
		.clk(clk),
		.rstb(rstb),
		.mem_rd_data(mem_rd_data),
		.mem_addr(mem_addr),
		.mem_wr_data(mem_wr_data),
		.mem_wr_ena(mem_wr_ena),
		.pc(pc)
	);

	// shared instruction and data memory
	mips_memory u_memory (
		.clk(clk),
		.addr(mem_addr),
		.wr_data(mem_wr_data),
		.wr_ena(mem_wr_ena),
		.rd_data(mem_rd_data)
	);

endmodule

//--- sim/mips_properties.sv
`timescale 1ns/10ps

module mips_properties (
	input logic clk,
	input logic rstb,
	input mips_isa_pkg::word_t pc,
	input mips_isa_pkg::word_t mem_addr,
	input logic mem_wr_ena
);

	// sw is followed by fetch which never writes
	single_write: assert property (@(posedge clk) disable iff (!rstb)
		mem_wr_ena |=> !mem_wr_ena)
		else $error("mem_wr_ena high in two consecutive cycles");

	pc_aligned: assert property (@(posedge clk) disable iff (!rstb) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

	write_aligned: assert property (@(posedge clk) disable iff (!rstb)
		mem_wr_ena |-> mem_addr[1:0] == 2'b00)
		else $error("store address not word aligned");

	// first cycle out of reset is a fetch
	quiet_after_reset: assert property (@(posedge clk) $rose(rstb) |-> !mem_wr_ena)
		else $error("mem_wr_ena high right after reset");

endmodule

bind mips_core mips_properties u_properties (
	.clk(clk),
	.rstb(rstb),
	.pc(pc),
	.mem_addr(mem_addr),
	.mem_wr_ena(mem_wr_ena)
);

//--- sim/tb_mips_system.sv
`timescale 1ns/10ps

module tb_mips_system;

	localparam int period_ns = 4;
	localparam int reset_cycles = 8;
	localparam int prog_words = 42;	// instruction words in program.hex
	localparam int margin_cycles = 200;	// reset tail plus final loop window
	localparam int timeout_ns = (prog_words * 5 + reset_cycles + margin_cycles) * period_ns;
	localparam int store_wait = 40;	// longest gap between two stores in cycles
	localparam int settle_cycles = 40;

	// immediates as encoded in program.hex
	localparam logic [15:0] imm_a = 16'hf0f3;	// addiu $1 makes the negative operand
	localparam logic [15:0] imm_b = 16'h5a6c;	// ori $2 makes the positive operand
	localparam logic [15:0] imm_addiu = 16'hfffd;	// -3
	localparam logic [15:0] imm_slti = 16'hfffb;	// -5
	localparam logic [15:0] imm_andi = 16'h8f0f;
	localparam logic [15:0] imm_ori = 16'h8001;
	localparam logic [15:0] imm_inc = 16'h0011;	// bump after lw
	localparam int sll_amt = 4;
	localparam int srl_amt = 8;

	// data addresses stay below the 4 KB wrap and miss the program words
	localparam mips_isa_pkg::word_t rtype_base = 32'h0000_0200;
	localparam mips_isa_pkg::word_t imm_base = 32'h0000_0240;
	localparam mips_isa_pkg::word_t ls_base = 32'h0000_0280;
	localparam mips_isa_pkg::word_t marker_base = 32'h0000_02c0;
	localparam mips_isa_pkg::word_t jal_addr = mips_isa_pkg::reset_pc + 32'h90;
	localparam mips_isa_pkg::word_t loop_addr = mips_isa_pkg::reset_pc + 32'ha4;

	typedef struct packed {
		mips_isa_pkg::word_t addr;
		mips_isa_pkg::word_t data;
	} store_t;

	logic clk;
	logic rstb;
	mips_isa_pkg::word_t pc;
	mips_isa_pkg::word_t mem_addr;
	mips_isa_pkg::word_t mem_wr_data;
	logic mem_wr_ena;
	store_t stores [$];	// writes seen on the memory port in order

	mips_system u_mips_system (
		.clk(clk),
		.rstb(rstb),
		.pc(pc),
		.mem_addr(mem_addr),
		.mem_wr_data(mem_wr_data),
		.mem_wr_ena(mem_wr_ena)
	);

	always #(period_ns / 2) clk = ~clk;

	// store monitor samples mid cycle where strobe and data are settled
	always @(negedge clk) begin
		if (mem_wr_ena === 1'b1) stores.push_back({mem_addr, mem_wr_data});
	end

	function automatic mips_isa_pkg::word_t sext16(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};	// arithmetic imm
	endfunction

	function automatic mips_isa_pkg::word_t zext16(input logic [15:0] imm);
		return {16'h0000, imm};	// andi / ori imm
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string name, input mips_isa_pkg::word_t got,
		input mips_isa_pkg::word_t want);
		if (got !== want) begin
			abort_run($sformatf("[ERROR] t=%0d ns: %s is %08h, expected %08h",
				$time, name, got, want));
		end
	endtask

	// waits for the next store and compares address and data
	task automatic expect_store(input string what, input mips_isa_pkg::word_t addr,
		input mips_isa_pkg::word_t data);
		store_t got;
		int waited;
		waited = 0;
		while (stores.size() == 0) begin
			if (waited >= store_wait) begin
				abort_run($sformatf("no store for %s within %0d cycles", what, store_wait));
			end else begin
				@(negedge clk);
				waited++;
			end
		end
		got = stores.pop_front();
		check_equal({what, " address"}, got.addr, addr);
		check_equal({what, " data"}, got.data, data);
	endtask

	task automatic reset_and_first_fetch();
		rstb = 1'b0;
		repeat (reset_cycles) begin
			@(negedge clk);
			check_equal("pc", pc, mips_isa_pkg::reset_pc);
			check_equal("mem_wr_ena", {31'b0, mem_wr_ena}, 32'd0);
		end
		rstb = 1'b1;	// released on a falling edge
		check_equal("mem_addr", mem_addr, mips_isa_pkg::reset_pc);	// first fetch address
	endtask

	task automatic rtype_ops();
		mips_isa_pkg::word_t a;
		mips_isa_pkg::word_t b;
		mips_isa_pkg::word_t want [9];
		int i;
		a = sext16(imm_a);
		b = zext16(imm_b);
		want[0] = a + b;	// addu
		want[1] = a - b;	// subu
		want[2] = a & b;
		want[3] = a | b;
		want[4] = a ^ b;
		want[5] = ~(a | b);
		want[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;	// signed compare with a negative
		want[7] = b << sll_amt;
		want[8] = a >> srl_amt;	// zero fill from the top
		for (i = 0; i < 9; i++) begin
			expect_store($sformatf("r-type %0d", i), rtype_base + 4 * i, want[i]);
		end
	endtask

	task automatic immediate_ops();
		mips_isa_pkg::word_t a;
		mips_isa_pkg::word_t b;
		a = sext16(imm_a);
		b = zext16(imm_b);
		expect_store("addiu", imm_base, b + sext16(imm_addiu));
		expect_store("slti", imm_base + 4,
			($signed(b) < $signed(sext16(imm_slti))) ? 32'd1 : 32'd0);
		expect_store("andi", imm_base + 8, a & zext16(imm_andi));	// upper half clears
		expect_store("ori", imm_base + 12, b | zext16(imm_ori));
	endtask

	task automatic load_store();
		mips_isa_pkg::word_t a;
		a = sext16(imm_a);
		expect_store("sw", ls_base, a);
		expect_store("lw then addiu", ls_base + 4, a + sext16(imm_inc));
	endtask

	// marker at +0 sits behind the taken beq so the next store is the one at +4
	task automatic branches_and_jumps();
		expect_store("bne marker", marker_base + 4, zext16(imm_b));
		expect_store("jal link", marker_base + 8, jal_addr + 4);
	endtask

	task automatic final_loop();
		int waited;
		waited = 0;
		while (pc !== loop_addr) begin
			if (waited >= store_wait) begin
				abort_run("pc never reached the final self-loop");
			end else begin
				@(negedge clk);
				waited++;
			end
		end
		// loop cycles through fetch decode and jump so pc is the loop or the word after it
		repeat (settle_cycles) begin
			@(negedge clk);
			if (pc !== loop_addr && pc !== loop_addr + 4) check_equal("pc", pc, loop_addr);
			check_equal("mem_wr_ena", {31'b0, mem_wr_ena}, 32'd0);
		end
		if (stores.size() != 0) begin
			abort_run($sformatf("%0d stores left over after the final jump", stores.size()));
		end
	endtask

	initial begin
		#(timeout_ns);
		abort_run($sformatf("watchdog expired after %0d ns, program did not finish", timeout_ns));
	end

	initial begin
		clk = 1'b0;
		rstb = 1'b0;
		reset_and_first_fetch();
		rtype_ops();
		immediate_ops();
		load_store();
		branches_and_jumps();
		final_loop();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- program.hex
// one 32-bit instruction word per column, loaded from word 0 (address 0x4000)
// a line holds one group of instructions, its comment lists them in order
2401F0F3 34025A6C                    // addiu $1,$0,0xf0f3 ; ori $2,$0,0x5a6c
00221821 AC030200 00221823 AC030204  // addu $3,$1,$2 ; sw 0x200 ; subu ; sw 0x204
00221824 AC030208 00221825 AC03020C  // and ; sw 0x208 ; or ; sw 0x20c
00221826 AC030210 00221827 AC030214  // xor ; sw 0x210 ; nor ; sw 0x214
0022182A AC030218                    // slt $3,$1,$2 ; sw 0x218
00021900 AC03021C 00011A02 AC030220  // sll $3,$2,4 ; sw 0x21c ; srl $3,$1,8 ; sw 0x220
2444FFFD AC040240 2844FFFB AC040244  // addiu $4,$2,-3 ; sw 0x240 ; slti $4,$2,-5 ; sw 0x244
30248F0F AC040248 34448001 AC04024C  // andi $4,$1,0x8f0f ; sw 0x248 ; ori $4,$2,0x8001 ; sw 0x24c
AC010280 8C050280 24A50011 AC050284  // sw $1 0x280 ; lw $5 0x280 ; addiu $5,$5,0x11 ; sw $5 0x284
10420001 AC0102C0                    // 0x4080 beq $2,$2,+1 ; marker sw 0x2c0 skipped
14420001 AC0202C4                    // 0x4088 bne $2,$2,+1 not taken ; marker sw 0x2c4
0C001026 AC0102CC                    // 0x4090 jal 0x4098 ; sw 0x2cc never runs
AC1F02C8 08001029                    // 0x4098 sw $31 0x2c8 ; j 0x40a4
AC0102D0 08001029                    // 0x40a0 sw 0x2d0 skipped ; 0x40a4 j 0x40a4 self-loop

//--- filelist.f
src/mips_isa_pkg.sv
src/mips_ctrl_pkg.sv
src/mips_alu.sv
src/mips_regfile.sv
src/mips_control.sv
src/mips_core.sv
src/mips_memory.sv
src/mips_system.sv
sim/mips_properties.sv
sim/tb_mips_system.sv

//--- Makefile
# Verilator build and run for the multicycle MIPS subsystem
VERILATOR ?= verilator
TOP ?= tb_mips_system
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run from the project root so program.hex is found
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
